// File: verilog/bf16_add_cfg.svh
// BF16 adder configuration
`ifndef BF16_ADD_CFG_SVH
`define BF16_ADD_CFG_SVH

// ==========================================================
// Field widths of the encoded word
// ==========================================================
`define BF16_W          16
`define BF16_EXP_W      8
`define BF16_MANT_W     7

// Internal significand widths
// Hidden bit plus mantissa plus guard, round and sticky
`define BF16_EXT_W      11
`define BF16_SUM_W      12

// Special encodings
`define BF16_EXP_MAX    8'd255
`define BF16_QNAN       16'h7FC0
`endif

// File: verilog/bf16_add_pkg.sv
// BF16 adder types
`include "bf16_add_cfg.svh"

package bf16_add_pkg;

    // Plain vectors with a meaning
    typedef logic [`BF16_W-1:0]      bf16_t;
    typedef logic [`BF16_EXP_W-1:0]  bf16_exp_t;
    typedef logic [`BF16_MANT_W-1:0] bf16_mant_t;
    typedef logic [`BF16_EXT_W-1:0]  bf16_ext_t;
    typedef logic [`BF16_SUM_W-1:0]  bf16_sum_t;
    // One extra bit so that values of zero or below stay visible
    typedef logic [`BF16_EXP_W:0]    bf16_sexp_t;

    // ==========================================================
    // Structs passed between pipeline stages
    // ==========================================================

    // Result decided in the first stage, carried to the output
    typedef struct packed {
        logic  hit;
        bf16_t value;
        logic  invalid;
    } bf16_special_t;

    // Operands ordered by magnitude
    typedef struct packed {
        logic       sign;
        logic       eff_sub;
        bf16_exp_t  exp_l;
        bf16_exp_t  exp_diff;
        bf16_mant_t mant_l;
        bf16_mant_t mant_s;
        logic       s_zero;
    } bf16_swapped_t;

    // Raw significand sum with carry
    typedef struct packed {
        logic      sign;
        bf16_exp_t exp_l;
        bf16_sum_t sum;
    } bf16_summed_t;

    // Normalized significand ahead of rounding
    typedef struct packed {
        logic       sign;
        bf16_sexp_t exp;
        bf16_ext_t  mant;
        logic       zero;
    } bf16_normed_t;

endpackage

// File: verilog/bf16_swap_stage.sv
// BF16 adder swap stage
`timescale 1ns/1ps
`include "bf16_add_cfg.svh"

module bf16_swap_stage (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  bf16_add_pkg::bf16_t         i_a,
    input  bf16_add_pkg::bf16_t         i_b,
    output logic                        o_valid,
    output bf16_add_pkg::bf16_special_t o_special,
    output bf16_add_pkg::bf16_swapped_t o_swapped
);

    // Unpacked operand fields
    logic                     sign_a, sign_b;
    bf16_add_pkg::bf16_exp_t  exp_a, exp_b;
    bf16_add_pkg::bf16_mant_t mant_a, mant_b;
    // Operand classes
    logic                     zero_a, zero_b;
    logic                     inf_a, inf_b;
    logic                     nan_a, nan_b;
    logic                     a_larger;
    bf16_add_pkg::bf16_special_t special;
    bf16_add_pkg::bf16_swapped_t swapped;

    // ==========================================================
    // Unpack and classify
    // ==========================================================
    assign sign_a = i_a[`BF16_W-1];
    assign exp_a  = i_a[`BF16_W-2 -: `BF16_EXP_W];
    assign mant_a = i_a[`BF16_MANT_W-1:0];
    assign sign_b = i_b[`BF16_W-1];
    assign exp_b  = i_b[`BF16_W-2 -: `BF16_EXP_W];
    assign mant_b = i_b[`BF16_MANT_W-1:0];

    // Zero exponent counts as zero, subnormals included (FTZ)
    assign zero_a = (exp_a == '0);
    assign zero_b = (exp_b == '0);
    assign inf_a  = (exp_a == `BF16_EXP_MAX) && (mant_a == '0);
    assign inf_b  = (exp_b == `BF16_EXP_MAX) && (mant_b == '0);
    assign nan_a  = (exp_a == `BF16_EXP_MAX) && (mant_a != '0);
    assign nan_b  = (exp_b == `BF16_EXP_MAX) && (mant_b != '0);

    // Special results in priority order
    always_comb begin
        special = '0;
        if (nan_a || nan_b) begin
            special.hit   = 1'b1;
            special.value = `BF16_QNAN;
        end else if (inf_a && inf_b && (sign_a != sign_b)) begin
            // Opposite infinities have no defined sum
            special.hit     = 1'b1;
            special.value   = `BF16_QNAN;
            special.invalid = 1'b1;
        end else if (inf_a || inf_b) begin
            special.hit   = 1'b1;
            special.value = inf_a ? i_a : i_b;
        end else if (zero_a && zero_b) begin
            // Negative only when both zeros are negative
            special.hit   = 1'b1;
            special.value = {sign_a & sign_b, {(`BF16_W-1){1'b0}}};
        end
    end

    // ==========================================================
    // Magnitude compare and swap
    // ==========================================================
    // Exponent first, mantissa breaks the tie
    assign a_larger = ({exp_a, mant_a} >= {exp_b, mant_b});

    always_comb begin
        swapped.sign     = a_larger ? sign_a : sign_b;
        swapped.eff_sub  = sign_a ^ sign_b;
        swapped.exp_l    = a_larger ? exp_a : exp_b;
        swapped.exp_diff = a_larger ? (exp_a - exp_b) : (exp_b - exp_a);
        swapped.mant_l   = a_larger ? mant_a : mant_b;
        swapped.mant_s   = a_larger ? mant_b : mant_a;
        swapped.s_zero   = a_larger ? zero_b : zero_a;
    end

    // Stage register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Data follows only accepted pairs
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_special <= special;
            o_swapped <= swapped;
        end
    end

endmodule

// File: verilog/bf16_align_add_stage.sv
// BF16 adder align and add stage
`timescale 1ns/1ps
`include "bf16_add_cfg.svh"

module bf16_align_add_stage (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  bf16_add_pkg::bf16_special_t i_special,
    input  bf16_add_pkg::bf16_swapped_t i_swapped,
    output logic                        o_valid,
    output bf16_add_pkg::bf16_special_t o_special,
    output bf16_add_pkg::bf16_summed_t  o_summed
);

    // Extended significands and alignment
    bf16_add_pkg::bf16_ext_t    ext_l, ext_s;
    bf16_add_pkg::bf16_ext_t    shifted, mask, aligned;
    logic                       sticky;
    bf16_add_pkg::bf16_summed_t summed;

    // ==========================================================
    // Alignment
    // ==========================================================
    // Hidden one on top, G/R/S cleared below
    assign ext_l = {1'b1, i_swapped.mant_l, {(`BF16_EXT_W-`BF16_MANT_W-1){1'b0}}};
    assign ext_s = {1'b1, i_swapped.mant_s, {(`BF16_EXT_W-`BF16_MANT_W-1){1'b0}}};

    // Shift clamps at full width, then every bit lands in sticky
    always_comb begin
        shifted = '0;
        mask    = '1;
        if (i_swapped.exp_diff < `BF16_EXT_W) begin
            shifted = ext_s >> i_swapped.exp_diff;
            mask    = (bf16_add_pkg::bf16_ext_t'(1) << i_swapped.exp_diff)
                      - bf16_add_pkg::bf16_ext_t'(1);
        end
        sticky = |(ext_s & mask);
    end

    // Sticky rides in the LSB so subtraction borrows from it
    assign aligned = i_swapped.s_zero ? '0
                   : {shifted[`BF16_EXT_W-1:1], shifted[0] | sticky};

    // ==========================================================
    // Add or subtract
    // ==========================================================
    always_comb begin
        summed.sign  = i_swapped.sign;
        summed.exp_l = i_swapped.exp_l;
        if (i_swapped.eff_sub) begin
            // Large minus small never goes negative
            summed.sum = {1'b0, ext_l} - {1'b0, aligned};
        end else begin
            summed.sum = {1'b0, ext_l} + {1'b0, aligned};
        end
    end

    // Stage register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_special <= i_special;
            o_summed  <= summed;
        end
    end

endmodule

// File: verilog/bf16_normalize_stage.sv
// BF16 adder normalize stage
`timescale 1ns/1ps
`include "bf16_add_cfg.svh"

module bf16_normalize_stage (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  bf16_add_pkg::bf16_special_t i_special,
    input  bf16_add_pkg::bf16_summed_t  i_summed,
    output logic                        o_valid,
    output bf16_add_pkg::bf16_special_t o_special,
    output bf16_add_pkg::bf16_normed_t  o_normed
);

    bf16_add_pkg::bf16_sum_t    sum;
    // Leading zero count below the carry bit
    logic [3:0]                 lz;
    bf16_add_pkg::bf16_normed_t normed;

    assign sum = i_summed.sum;

    // ==========================================================
    // Leading zero count
    // ==========================================================
    // Highest set bit wins, an all-zero sum counts full width
    always_comb begin
        lz = 4'(`BF16_EXT_W);
        for (int i = 0; i < `BF16_EXT_W; i++) begin
            if (sum[i]) begin
                lz = 4'(`BF16_EXT_W - 1 - i);
            end
        end
    end

    // ==========================================================
    // Normalizing shift and exponent adjust
    // ==========================================================
    always_comb begin
        normed.sign = i_summed.sign;
        normed.zero = (sum == '0);
        if (sum[`BF16_SUM_W-1]) begin
            // Carry out: drop one bit into sticky
            normed.mant = {sum[`BF16_SUM_W-1:2], sum[1] | sum[0]};
            normed.exp  = {1'b0, i_summed.exp_l} + 9'd1;
        end else begin
            // Cancellation pulls the leading one back up
            normed.mant = sum[`BF16_EXT_W-1:0] << lz;
            normed.exp  = {1'b0, i_summed.exp_l} - {5'd0, lz};
        end
    end

    // Stage register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_special <= i_special;
            o_normed  <= normed;
        end
    end

endmodule

// File: verilog/bf16_round_select.sv
// BF16 adder round and select stage
`timescale 1ns/1ps
`include "bf16_add_cfg.svh"

module bf16_round_select (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  bf16_add_pkg::bf16_special_t i_special,
    input  bf16_add_pkg::bf16_normed_t  i_normed,
    output logic                        o_valid,
    output bf16_add_pkg::bf16_t         o_result,
    output logic                        o_overflow,
    output logic                        o_underflow,
    output logic                        o_invalid
);

    bf16_add_pkg::bf16_mant_t mant;
    logic                     guard, round_bit, sticky, round_up;
    // Rounded mantissa with carry on top
    logic [`BF16_MANT_W:0]    rounded;
    bf16_add_pkg::bf16_sexp_t exp_r;
    logic                     uflow, oflow;
    bf16_add_pkg::bf16_t      result;
    logic                     ovf_flag, unf_flag, inv_flag;

    // ==========================================================
    // Round to nearest even
    // ==========================================================
    assign mant      = i_normed.mant[`BF16_EXT_W-2 -: `BF16_MANT_W];
    assign guard     = i_normed.mant[2];
    assign round_bit = i_normed.mant[1];
    assign sticky    = i_normed.mant[0];
    // Exact ties go to the even mantissa
    assign round_up  = guard & (round_bit | sticky | mant[0]);
    assign rounded   = {1'b0, mant} + {{`BF16_MANT_W{1'b0}}, round_up};
    // Mantissa wrap bumps the exponent
    assign exp_r     = i_normed.exp + {{`BF16_EXP_W{1'b0}}, rounded[`BF16_MANT_W]};

    // Underflow judged before rounding
    assign uflow = i_normed.exp[`BF16_EXP_W] || (i_normed.exp == '0);
    assign oflow = (exp_r >= `BF16_EXP_MAX);

    // ==========================================================
    // Result select
    // ==========================================================
    always_comb begin
        result   = {i_normed.sign, exp_r[`BF16_EXP_W-1:0], rounded[`BF16_MANT_W-1:0]};
        ovf_flag = 1'b0;
        unf_flag = 1'b0;
        inv_flag = 1'b0;
        if (i_special.hit) begin
            result   = i_special.value;
            inv_flag = i_special.invalid;
        end else if (i_normed.zero) begin
            // Exact cancellation gives positive zero
            result = '0;
        end else if (uflow) begin
            result   = {i_normed.sign, {(`BF16_W-1){1'b0}}};
            unf_flag = 1'b1;
        end else if (oflow) begin
            result   = {i_normed.sign, `BF16_EXP_MAX, {`BF16_MANT_W{1'b0}}};
            ovf_flag = 1'b1;
        end
    end

    // Output register, flags only with a valid result
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_result    <= '0;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
            o_invalid   <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_overflow  <= i_valid & ovf_flag;
            o_underflow <= i_valid & unf_flag;
            o_invalid   <= i_valid & inv_flag;
            if (i_valid) begin
                o_result <= result;
            end
        end
    end

endmodule

// File: verilog/bf16_add_top.sv
// BF16 adder top
`timescale 1ns/1ps

module bf16_add_top (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    input  bf16_add_pkg::bf16_t i_a,
    input  bf16_add_pkg::bf16_t i_b,
    output logic                o_valid,
    output bf16_add_pkg::bf16_t o_result,
    output logic                o_overflow,
    output logic                o_underflow,
    output logic                o_invalid
);

    // ==========================================================
    // Inter-stage wires
    // ==========================================================
    logic                        swap_valid, sum_valid, norm_valid;
    bf16_add_pkg::bf16_special_t swap_special, sum_special, norm_special;
    bf16_add_pkg::bf16_swapped_t swapped;
    bf16_add_pkg::bf16_summed_t  summed;
    bf16_add_pkg::bf16_normed_t  normed;

    // Four stages, one cycle each
    bf16_swap_stage u_swap (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_a(i_a), .i_b(i_b),
        .o_valid(swap_valid), .o_special(swap_special), .o_swapped(swapped)
    );

    bf16_align_add_stage u_align_add (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(swap_valid),
        .i_special(swap_special), .i_swapped(swapped),
        .o_valid(sum_valid), .o_special(sum_special), .o_summed(summed)
    );

    bf16_normalize_stage u_normalize (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(sum_valid),
        .i_special(sum_special), .i_summed(summed),
        .o_valid(norm_valid), .o_special(norm_special), .o_normed(normed)
    );

    bf16_round_select u_round (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(norm_valid),
        .i_special(norm_special), .i_normed(normed),
        .o_valid(o_valid), .o_result(o_result), .o_overflow(o_overflow),
        .o_underflow(o_underflow), .o_invalid(o_invalid)
    );

endmodule

// File: verification/bf16_add_checker.sv
// BF16 adder result checker
`timescale 1ns/1ps
`include "bf16_add_cfg.svh"

module bf16_add_checker (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    input  bf16_add_pkg::bf16_t i_a,
    input  bf16_add_pkg::bf16_t i_b,
    input  logic                i_dut_valid,
    input  bf16_add_pkg::bf16_t i_dut_result,
    input  logic                i_dut_overflow,
    input  logic                i_dut_underflow,
    input  logic                i_dut_invalid,
    output int                  o_checks,
    output int                  o_errors,
    output int                  o_pending
);

    localparam int LATENCY = 4;
    // Grid bits kept below the hidden one of the larger operand
    localparam int GRID = 40;

    // Entry packs a and b, then the invalid, underflow and overflow flags and the result
    logic [50:0] exp_q[$];
    int          stamp_q[$];
    logic [50:0] entry;
    int          cycle = 0;
    int          since_reset = 0;
    int          age;
    int          checks = 0;
    int          errors = 0;
    int          pending = 0;
    string       ctx;

    assign o_checks  = checks;
    assign o_errors  = errors;
    assign o_pending = pending;

    // ==========================================================
    // Reference model
    // ==========================================================
    // Significand placed on the grid
    // Far-off operands shrink to a single sticky unit
    function automatic longint align_sig(input logic [7:0] sig, input int d);
        if (d > GRID) begin
            return 64'sd1;
        end
        return longint'(sig) << (GRID - d);
    endfunction

    function automatic logic [18:0] model_add(input logic [15:0] a, input logic [15:0] b);
        logic       sign;
        logic [7:0] el;
        logic       nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;
        longint     va, vb, sum, mag, kept, rem, half;
        int         p, sh, e;
        nan_a  = (a[14:7] == 8'hff) && (a[6:0] != 7'h00);
        nan_b  = (b[14:7] == 8'hff) && (b[6:0] != 7'h00);
        inf_a  = (a[14:7] == 8'hff) && (a[6:0] == 7'h00);
        inf_b  = (b[14:7] == 8'hff) && (b[6:0] == 7'h00);
        // Subnormals flush to zero
        zero_a = (a[14:7] == 8'h00);
        zero_b = (b[14:7] == 8'h00);
        if (nan_a || nan_b) begin
            return {3'b000, `BF16_QNAN};
        end
        if (inf_a && inf_b && (a[15] != b[15])) begin
            return {3'b100, `BF16_QNAN};
        end
        if (inf_a) begin
            return {3'b000, a};
        end
        if (inf_b) begin
            return {3'b000, b};
        end
        if (zero_a && zero_b) begin
            return {3'b000, a[15] & b[15], 15'h0000};
        end
        // Exact signed sum on a common grid
        el  = (a[14:7] > b[14:7]) ? a[14:7] : b[14:7];
        va  = zero_a ? 64'sd0 : align_sig({1'b1, a[6:0]}, int'(el) - int'(a[14:7]));
        vb  = zero_b ? 64'sd0 : align_sig({1'b1, b[6:0]}, int'(el) - int'(b[14:7]));
        sum = (a[15] ? -va : va) + (b[15] ? -vb : vb);
        if (sum == 64'sd0) begin
            return {3'b000, 16'h0000};
        end
        sign = (sum < 64'sd0);
        mag  = sign ? -sum : sum;
        p    = 0;
        for (int i = 0; i < 62; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        // Hidden one of the larger operand sits at GRID + 7
        e = int'(el) + p - (GRID + 7);
        if (e <= 0) begin
            return {3'b010, sign, 15'h0000};
        end
        // Nearest even on the bits below the kept eight
        sh   = p - 7;
        kept = mag >>> sh;
        rem  = mag & ((64'sd1 <<< sh) - 64'sd1);
        half = 64'sd1 <<< (sh - 1);
        if ((rem > half) || ((rem == half) && kept[0])) begin
            kept = kept + 64'sd1;
        end
        if (kept == 64'sd256) begin
            kept = 64'sd128;
            e    = e + 1;
        end
        if (e >= 255) begin
            return {3'b001, sign, 8'hff, 7'h00};
        end
        return {3'b000, sign, e[7:0], kept[6:0]};
    endfunction

    // ==========================================================
    // Comparison
    // ==========================================================
    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] want, input string where);
        if (got !== want) begin
            $display("Error: %s = %h, expected %h %s", name, got, want, where);
            errors = errors + 1;
        end
    endtask

    always @(posedge i_clk) begin
        cycle = cycle + 1;
        if (!i_rst_n || (since_reset == 0)) begin
            // Outputs quiet through reset and one cycle past it
            check_field("o_valid", {15'd0, i_dut_valid}, 16'h0000, "around reset");
            check_field("o_result", i_dut_result, 16'h0000, "around reset");
            check_field("o_overflow", {15'd0, i_dut_overflow}, 16'h0000, "around reset");
            check_field("o_underflow", {15'd0, i_dut_underflow}, 16'h0000, "around reset");
            check_field("o_invalid", {15'd0, i_dut_invalid}, 16'h0000, "around reset");
        end
        if (!i_rst_n) begin
            since_reset = 0;
        end else begin
            since_reset = since_reset + 1;
            if (i_dut_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Result %h came out with no operand pair outstanding",
                             i_dut_result);
                    errors = errors + 1;
                end else begin
                    entry  = exp_q.pop_front();
                    age    = cycle - stamp_q.pop_front();
                    ctx    = $sformatf("for a %h b %h", entry[50:35], entry[34:19]);
                    checks = checks + 1;
                    check_field("o_result", i_dut_result, entry[15:0], ctx);
                    check_field("o_overflow", {15'd0, i_dut_overflow}, {15'd0, entry[16]}, ctx);
                    check_field("o_underflow", {15'd0, i_dut_underflow}, {15'd0, entry[17]}, ctx);
                    check_field("o_invalid", {15'd0, i_dut_invalid}, {15'd0, entry[18]}, ctx);
                    if (age != LATENCY) begin
                        $display("Result %s arrived %0d cycles after its input instead of %0d",
                                 ctx, age, LATENCY);
                        errors = errors + 1;
                    end
                end
            end else if (i_dut_overflow || i_dut_underflow || i_dut_invalid) begin
                $display("A flag was raised while o_valid was low");
                errors = errors + 1;
            end
            // Accepted pair joins the expected queue
            if (i_valid) begin
                exp_q.push_back({i_a, i_b, model_add(i_a, i_b)});
                stamp_q.push_back(cycle);
            end
        end
        pending = exp_q.size();
    end

endmodule

// File: verification/tb_bf16_add.sv
// BF16 adder testbench
`timescale 1ns/1ps

module tb_bf16_add;

    localparam int LATENCY       = 4;
    localparam int RST_CYCLES    = 2;
    localparam int NORMAL_SLOTS  = 300;
    localparam int SPECIAL_SLOTS = 150;
    localparam int RANGE_SLOTS   = 100;
    localparam int STREAM_SLOTS  = 200;
    localparam int TEST_COUNT    = 4;
    // One cycle per slot, a drain per test, the final idle cycles and a margin
    localparam int CYCLE_LIMIT = RST_CYCLES + 1 + NORMAL_SLOTS + SPECIAL_SLOTS + RANGE_SLOTS
                               + STREAM_SLOTS + TEST_COUNT * (LATENCY + 2) + 8 + 50;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_valid;
    logic [15:0] i_a;
    logic [15:0] i_b;
    logic        o_valid;
    logic [15:0] o_result;
    logic        o_overflow;
    logic        o_underflow;
    logic        o_invalid;
    int          checks;
    int          errors;
    int          pending;
    int          lost;
    int          cycles;
    logic [31:0] lfsr_state;

    bf16_add_top dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_a(i_a), .i_b(i_b),
        .o_valid(o_valid), .o_result(o_result), .o_overflow(o_overflow),
        .o_underflow(o_underflow), .o_invalid(o_invalid)
    );

    bf16_add_checker u_checker (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_a(i_a), .i_b(i_b),
        .i_dut_valid(o_valid), .i_dut_result(o_result), .i_dut_overflow(o_overflow),
        .i_dut_underflow(o_underflow), .i_dut_invalid(o_invalid),
        .o_checks(checks), .o_errors(errors), .o_pending(pending)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ==========================================================
    // Random source
    // ==========================================================
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = 16'h0000;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_step()};
        end
        return v;
    endfunction

    // Keeps an exponent in the normal range
    function automatic logic [7:0] clamp_exp(input int e);
        if (e < 1) begin
            return 8'd1;
        end
        if (e > 254) begin
            return 8'd254;
        end
        return 8'(e);
    endfunction

    function automatic logic [15:0] pick_special();
        logic [15:0] v;
        logic [15:0] cls;
        v   = rand_bits(16);
        cls = rand_bits(3);
        case (cls)
            16'd0:   v[14:0] = 15'h0000;
            16'd1:   v[14:7] = 8'h00;               // subnormal, flushed
            16'd2:   v[14:0] = {8'hff, 7'h00};
            16'd3:   v[14:0] = {8'hff, v[6:0] | 7'h01};
            default: v[14:7] = clamp_exp(int'(v[14:7]));
        endcase
        return v;
    endfunction

    // ==========================================================
    // Stimulus
    // ==========================================================
    task automatic pick_pair(input int kind, output logic [15:0] a, output logic [15:0] b);
        a = rand_bits(16);
        b = rand_bits(16);
        case (kind)
            0: begin
                a[14:7] = clamp_exp(int'(a[14:7]));
                // Close exponents for cancellation and ties
                if (rand_bits(1) != 16'd0) begin
                    b[14:7] = clamp_exp(int'(a[14:7]) + int'(rand_bits(3)) - 4);
                end else begin
                    b[14:7] = clamp_exp(int'(b[14:7]));
                end
            end
            1: begin
                a = pick_special();
                b = pick_special();
            end
            2: begin
                if (rand_bits(1) != 16'd0) begin
                    // Top exponents of one sign
                    a[14:7] = 8'd254;
                    b[15]   = a[15];
                    b[14:7] = (rand_bits(1) != 16'd0) ? 8'd253 : 8'd254;
                end else begin
                    // Near-equal tiny magnitudes of opposite sign
                    a[14:7] = (rand_bits(1) != 16'd0) ? 8'd2 : 8'd1;
                    b       = a ^ 16'h8000 ^ rand_bits(2);
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic run_test(input string name, input int kind, input int slots);
        int          err0;
        int          chk0;
        logic [15:0] a;
        logic [15:0] b;
        logic        v;
        err0 = errors;
        chk0 = checks;
        for (int s = 0; s < slots; s++) begin
            pick_pair(kind, a, b);
            // Streaming idles more often
            v = (kind == 3) ? (rand_bits(2) != 16'd0) : (rand_bits(3) != 16'd0);
            @(negedge i_clk);
            i_valid = v;
            i_a     = a;
            i_b     = b;
        end
        @(negedge i_clk);
        i_valid = 1'b0;
        while (pending != 0) begin
            @(negedge i_clk);
        end
        $display("test %s: %0d results checked, %0d errors", name, checks - chk0,
                 errors - err0);
    endtask

    initial begin
        lfsr_state = 32'hc451;
        lost       = 0;
        i_rst_n    = 1'b0;
        i_valid    = 1'b0;
        i_a        = 16'h0000;
        i_b        = 16'h0000;
        repeat (RST_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        $display("test reset: %0d errors", errors);
        run_test("normals", 0, NORMAL_SLOTS);
        run_test("specials", 1, SPECIAL_SLOTS);
        run_test("range", 2, RANGE_SLOTS);
        run_test("streaming", 3, STREAM_SLOTS);
        repeat (8) @(negedge i_clk);
        if (pending != 0) begin
            $display("%0d operand pairs never produced a result", pending);
            lost = pending;
        end
        $display("%0d results checked, %0d errors", checks, errors + lost);
        if ((errors + lost) == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog on the cycle count
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycles = cycles + 1;
        end
        $display("Timeout: run stopped after %0d cycles", cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/bf16_add_pkg.sv
verilog/bf16_swap_stage.sv
verilog/bf16_align_add_stage.sv
verilog/bf16_normalize_stage.sv
verilog/bf16_round_select.sv
verilog/bf16_add_top.sv
verification/bf16_add_checker.sv
verification/tb_bf16_add.sv

// File: Makefile
TOP = tb_bf16_add

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
